// File: Makefile
VERILATOR ?= verilator
TOP       := tb_dither_lock
FILELIST  := dither_lock_top.f
VFLAGS    := --binary --timing --assert -j 0
SIM_ARGS  := +verilator+error+limit+100
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run FAILED"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/dither_lock_top.sv
/*
 * dither lock top: modulation generator, error demodulator and loop
 * integrator, with the last handed-off error exported for monitoring
 */
`timescale 1ns/100ps

module dither_lock_top #(
    parameter int ADC_BIT = 14,
    parameter int ACT_BIT = 16
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_enable,
    input  lock_cfg_pkg::lock_cfg_t   i_cfg,
    input  logic signed [ADC_BIT-1:0] i_adc_data,
    output logic                      o_mod,
    output lock_cfg_pkg::lock_err_t   o_err,
    output logic signed [ACT_BIT-1:0] o_act,
    output logic                      o_act_valid
);

    logic err_req;
    logic err_ack;

    dither_mod_gen u_mod_gen (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_enable      (i_enable),
        .i_half_period (i_cfg.half_period),
        .o_mod         (o_mod)
    );

    // o_err is the demodulator's sample register, stable across each handoff
    err_demod #(
        .ADC_BIT (ADC_BIT)
    ) u_demod (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_enable),
        .i_cfg        (i_cfg),
        .i_mod        (o_mod),
        .i_adc_data   (i_adc_data),
        .o_err_req    (err_req),
        .o_err_sample (o_err),
        .i_err_ack    (err_ack)
    );

    loop_integrator #(
        .ACT_BIT (ACT_BIT)
    ) u_integ (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_err_req    (err_req),
        .i_err_sample (o_err),
        .o_err_ack    (err_ack),
        .i_gain_shift (i_cfg.gain_shift),
        .o_act        (o_act),
        .o_act_valid  (o_act_valid)
    );

endmodule

// File: design/dither_mod_gen.sv
/*
 * dither modulation generator: square wave with a programmable half period,
 * restarting with a fresh high half every time it is enabled
 */
`timescale 1ns/100ps

module dither_mod_gen (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_enable,
    input  logic [15:0] i_half_period,
    output logic        o_mod
);

    logic [15:0] half_cnt;
    logic        half_done;

    assign half_done = (half_cnt == 16'd0);  // also true on the first enabled cycle

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            half_cnt <= 16'd0;
            o_mod    <= 1'b0;
        end else if (!i_enable) begin
            half_cnt <= 16'd0;  // next enable starts straight into a high half
            o_mod    <= 1'b0;
        end else if (half_done) begin
            o_mod    <= ~o_mod;
            half_cnt <= i_half_period - 16'd1;  // toggle again half_period edges later
        end else begin
            half_cnt <= half_cnt - 16'd1;
        end
    end

endmodule

// File: design/err_demod.sv
/*
 * error demodulator: settles and averages each modulation half, then forms
 * the offset, polarity and deadband corrected error and hands it off
 */
`timescale 1ns/100ps

module err_demod #(
    parameter int ADC_BIT = 14
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_enable,
    input  lock_cfg_pkg::lock_cfg_t   i_cfg,
    input  logic                      i_mod,
    input  logic signed [ADC_BIT-1:0] i_adc_data,
    output logic                      o_err_req,
    output lock_cfg_pkg::lock_err_t   o_err_sample,
    input  logic                      i_err_ack
);

    import lock_cfg_pkg::*;
    import lock_ctrl_pkg::*;

    demod_state_e       cstate;
    demod_state_e       nstate;
    lock_cfg_t          cfg_q;
    logic               mod_q;
    logic               mod_rise;
    logic               mod_fall;
    logic [15:0]        settle_cnt;
    logic [6:0]         smp_cnt;
    logic [6:0]         smp_load;
    logic signed [31:0] adc_ext;
    logic signed [31:0] sum_h;
    logic signed [31:0] sum_l;
    logic signed [31:0] avg_h;
    logic signed [31:0] avg_l;
    logic signed [31:0] raw_diff;
    logic signed [32:0] raw_ext;
    logic signed [32:0] thr_ext;
    logic               in_band;
    lock_err_t          err_next;

    assign mod_rise = i_mod & ~mod_q;
    assign mod_fall = ~i_mod & mod_q;

    assign adc_ext  = {{(32-ADC_BIT){i_adc_data[ADC_BIT-1]}}, i_adc_data};
    assign smp_load = (7'd1 << cfg_q.avg_len) - 7'd1;

    // the sums are complete by the time the FSM reaches DM_CALC
    assign avg_h    = (sum_h >>> cfg_q.avg_len) + cfg_q.offset;
    assign avg_l    = sum_l >>> cfg_q.avg_len;
    assign raw_diff = cfg_q.polarity ? (avg_l - avg_h) : (avg_h - avg_l);

    // one extra bit so the full threshold range can be negated
    assign raw_ext = {raw_diff[31], raw_diff};
    assign thr_ext = {2'b00, cfg_q.threshold};
    assign in_band = (raw_ext <= thr_ext) && (raw_ext >= -thr_ext);

    assign err_next.value   = in_band ? 32'sd0 : raw_diff;
    assign err_next.in_band = in_band;

    always_comb begin
        nstate = cstate;
        case (cstate)
            DM_IDLE: begin
                if (i_enable) nstate = DM_WAIT_H;
            end
            DM_WAIT_H: begin
                if (mod_rise) nstate = (cfg_q.settle == 16'd0) ? DM_ACQ_H : DM_SETTLE_H;
            end
            DM_SETTLE_H: begin
                if (settle_cnt == 16'd0) nstate = DM_ACQ_H;
            end
            DM_ACQ_H: begin
                if (smp_cnt == 7'd0) nstate = DM_WAIT_L;
            end
            DM_WAIT_L: begin
                if (mod_fall) nstate = (cfg_q.settle == 16'd0) ? DM_ACQ_L : DM_SETTLE_L;
            end
            DM_SETTLE_L: begin
                if (settle_cnt == 16'd0) nstate = DM_ACQ_L;
            end
            DM_ACQ_L: begin
                if (smp_cnt == 7'd0) nstate = DM_CALC;
            end
            DM_CALC: nstate = DM_HANDOFF;
            DM_HANDOFF: begin
                // leave only once both req and ack are back low
                if (!o_err_req && !i_err_ack) nstate = i_enable ? DM_WAIT_H : DM_IDLE;
            end
            default: nstate = DM_IDLE;
        endcase
        // a pending handoff always completes so the handshake stays legal
        if (!i_enable && cstate != DM_HANDOFF) nstate = DM_IDLE;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cstate       <= DM_IDLE;
            mod_q        <= 1'b0;
            settle_cnt   <= 16'd0;
            smp_cnt      <= 7'd0;
            o_err_req    <= 1'b0;
            o_err_sample <= '0;
        end else begin
            cstate <= nstate;
            mod_q  <= i_mod;
            case (cstate)
                DM_WAIT_H, DM_WAIT_L: begin
                    settle_cnt <= cfg_q.settle - 16'd1;
                    smp_cnt    <= smp_load;  // also covers a zero settle time
                end
                DM_SETTLE_H, DM_SETTLE_L: begin
                    if (settle_cnt != 16'd0) settle_cnt <= settle_cnt - 16'd1;
                end
                DM_ACQ_H, DM_ACQ_L: begin
                    if (smp_cnt != 7'd0) smp_cnt <= smp_cnt - 7'd1;
                end
                DM_CALC: begin
                    o_err_req    <= 1'b1;
                    o_err_sample <= err_next;  // held until the next calc cycle
                end
                DM_HANDOFF: begin
                    if (i_err_ack) o_err_req <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (nstate == DM_WAIT_H && cstate != DM_WAIT_H) cfg_q <= i_cfg;
        case (cstate)
            DM_WAIT_H: sum_h <= 32'sd0;
            DM_ACQ_H:  sum_h <= sum_h + adc_ext;
            DM_WAIT_L: sum_l <= 32'sd0;
            DM_ACQ_L:  sum_l <= sum_l + adc_ext;
            default: ;
        endcase
    end

endmodule

// File: design/lock_cfg_pkg.sv
/*
 * lock loop configuration and data types: servo config word, averaging
 * length and the error sample passed from demodulator to integrator
 */
package lock_cfg_pkg;

    // sample count is 2**value, the value doubles as the averaging shift
    typedef enum logic [2:0] {
        AVG_1  = 3'd0,
        AVG_2  = 3'd1,
        AVG_4  = 3'd2,
        AVG_8  = 3'd3,
        AVG_16 = 3'd4,
        AVG_32 = 3'd5,
        AVG_64 = 3'd6
    } avg_len_e;

    typedef struct packed {
        logic [15:0]        half_period;  // cycles per modulation half
        logic [15:0]        settle;       // cycles skipped after each edge
        avg_len_e           avg_len;
        logic               polarity;     // 1 flips the sign of the error
        logic signed [31:0] offset;       // added to the high half average
        logic [30:0]        threshold;    // deadband half width
        logic [3:0]         gain_shift;   // integrator gain as a right shift
    } lock_cfg_t;

    typedef struct packed {
        logic signed [31:0] value;        // error after the deadband
        logic               in_band;      // raw error was inside the deadband
    } lock_err_t;

endpackage

// File: design/lock_ctrl_pkg.sv
/*
 * control state encodings for the demodulator and integrator FSMs
 */
package lock_ctrl_pkg;

    typedef enum logic [3:0] {
        DM_IDLE,
        DM_WAIT_H,
        DM_SETTLE_H,
        DM_ACQ_H,
        DM_WAIT_L,
        DM_SETTLE_L,
        DM_ACQ_L,
        DM_CALC,
        DM_HANDOFF
    } demod_state_e;

    typedef enum logic [1:0] {
        IN_IDLE,
        IN_ACK,
        IN_RELEASE
    } integ_state_e;

endpackage

// File: design/loop_integrator.sv
/*
 * loop integrator: accepts error samples over a four-phase handshake and
 * accumulates the gain-shifted error into a saturated actuator word
 */
`timescale 1ns/100ps

module loop_integrator #(
    parameter int ACT_BIT = 16
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_err_req,
    input  lock_cfg_pkg::lock_err_t   i_err_sample,
    output logic                      o_err_ack,
    input  logic [3:0]                i_gain_shift,
    output logic signed [ACT_BIT-1:0] o_act,
    output logic                      o_act_valid
);

    import lock_ctrl_pkg::*;

    // one guard bit above the wider of the two operands
    localparam int SUM_BIT = ((ACT_BIT > 32) ? ACT_BIT : 32) + 1;
    localparam logic signed [SUM_BIT-1:0] ACT_MAX =
        $signed({{(SUM_BIT-ACT_BIT+1){1'b0}}, {(ACT_BIT-1){1'b1}}});
    localparam logic signed [SUM_BIT-1:0] ACT_MIN =
        $signed({{(SUM_BIT-ACT_BIT+1){1'b1}}, {(ACT_BIT-1){1'b0}}});

    integ_state_e              state;
    logic signed [31:0]        err_val;
    logic signed [31:0]        err_scaled;
    logic signed [SUM_BIT-1:0] sum;
    logic signed [ACT_BIT-1:0] act_next;

    assign err_val    = i_err_sample.value;
    assign err_scaled = err_val >>> i_gain_shift;
    assign sum = {{(SUM_BIT-ACT_BIT){o_act[ACT_BIT-1]}}, o_act}
               + {{(SUM_BIT-32){err_scaled[31]}}, err_scaled};

    always_comb begin
        if (sum > ACT_MAX) begin
            act_next = ACT_MAX[ACT_BIT-1:0];
        end else if (sum < ACT_MIN) begin
            act_next = ACT_MIN[ACT_BIT-1:0];
        end else begin
            act_next = sum[ACT_BIT-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= IN_IDLE;
            o_err_ack   <= 1'b0;
            o_act       <= '0;
            o_act_valid <= 1'b0;
        end else begin
            o_act_valid <= 1'b0;
            case (state)
                IN_IDLE: begin
                    if (i_err_req) begin
                        state       <= IN_ACK;
                        o_err_ack   <= 1'b1;
                        o_act       <= act_next;  // sample is consumed on the ack edge
                        o_act_valid <= 1'b1;
                    end
                end
                IN_ACK: begin
                    if (!i_err_req) begin
                        state     <= IN_RELEASE;
                        o_err_ack <= 1'b0;
                    end
                end
                IN_RELEASE: state <= IN_IDLE;  // ack stays low for at least a cycle
                default:    state <= IN_IDLE;
            endcase
        end
    end

endmodule

// File: dither_lock_top.f
design/lock_cfg_pkg.sv
design/lock_ctrl_pkg.sv
design/dither_mod_gen.sv
design/err_demod.sv
design/loop_integrator.sv
design/dither_lock_top.sv
testbench/dither_lock_chk.sv
testbench/tb_dither_lock.sv

// File: testbench/dither_lock_chk.sv
/*
 * dither lock checker: reset values, modulation period, error values,
 * handshake order and saturated actuator updates
 */
`timescale 1ns/100ps

module dither_lock_chk #(
    parameter int ACT_BIT = 16
) (
    input logic                      i_clk,
    input logic                      i_rst_n,
    input logic                      i_enable,
    input lock_cfg_pkg::lock_cfg_t   i_cfg,
    input logic                      i_mod,
    input lock_cfg_pkg::lock_err_t   i_err,
    input logic signed [ACT_BIT-1:0] i_act,
    input logic                      i_act_valid,
    input logic                      i_err_req,
    input logic                      i_err_ack
);

    int                        fail_cnt;
    logic                      mod_q;
    logic                      seen_tog;
    logic [15:0]               since;
    logic [15:0]               en_cnt;
    logic signed [ACT_BIT-1:0] act_prev;
    logic signed [ACT_BIT-1:0] exp_act;
    logic signed [31:0]        exp_value;
    logic                      exp_in_band;
    longint                    raw;

    function automatic logic signed [ACT_BIT-1:0] sat_add(input logic signed [ACT_BIT-1:0] act,
                                                          input logic signed [31:0] err,
                                                          input logic [3:0] sh);
        longint hi;
        longint sum;
        hi  = (longint'(1) << (ACT_BIT - 1)) - 1;
        sum = longint'(act) + (longint'(err) >>> sh);
        if (sum > hi) begin
            sum = hi;
        end else if (sum < -hi - 1) begin
            sum = -hi - 1;
        end
        return sum[ACT_BIT-1:0];
    endfunction

    task automatic note_failure(input string msg);
        $error("%s", msg);
        fail_cnt = fail_cnt + 1;
    endtask

    initial fail_cnt = 0;

    // the plant is two constant levels, so both averages are exact
    always_comb begin
        raw = longint'(tb_dither_lock.level_h) + longint'(i_cfg.offset)
            - longint'(tb_dither_lock.level_l);
        if (i_cfg.polarity) raw = -raw;
        exp_in_band = (raw <= longint'(i_cfg.threshold)) && (raw >= -longint'(i_cfg.threshold));
        exp_value   = exp_in_band ? 32'sd0 : raw[31:0];
        exp_act     = sat_add(act_prev, exp_value, i_cfg.gain_shift);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mod_q    <= 1'b0;
            seen_tog <= 1'b0;
            since    <= 16'd0;
            en_cnt   <= 16'd0;
            act_prev <= '0;
        end else begin
            mod_q    <= i_mod;
            act_prev <= i_act;
            if (!i_enable) begin
                seen_tog <= 1'b0;
                since    <= 16'd0;
                en_cnt   <= 16'd0;
            end else begin
                if (en_cnt != 16'hffff) en_cnt <= en_cnt + 16'd1;
                if (i_mod != mod_q) begin
                    seen_tog <= 1'b1;  // the first toggle after enable only starts the count
                    since    <= 16'd1;
                end else begin
                    since <= since + 16'd1;
                end
            end
        end
    end

    a_reset: assert property (@(posedge i_clk) (!i_rst_n || $rose(i_rst_n)) |->
        !i_mod && !i_act_valid && !i_err_req && !i_err_ack && i_act == '0)
        else note_failure("outputs or handshake not cleared during reset");
    a_period: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_enable && seen_tog && i_mod != mod_q) |-> since == i_cfg.half_period)
        else note_failure($sformatf("ERROR t=%0t o_mod half period got %0d exp %0d",
            $time, $sampled(since), $sampled(i_cfg.half_period)));
    a_err_value: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_act_valid |-> i_err.value == exp_value)
        else note_failure($sformatf("ERROR t=%0t o_err.value got %0d exp %0d",
            $time, $sampled(i_err.value), $sampled(exp_value)));
    a_err_band: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_act_valid |-> i_err.in_band == exp_in_band)
        else note_failure($sformatf("ERROR t=%0t o_err.in_band got %0b exp %0b",
            $time, $sampled(i_err.in_band), $sampled(exp_in_band)));
    a_sample_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ($past(i_err_req) && i_err_req) |-> $stable(i_err))
        else note_failure("error sample changed while req was high");
    a_ack_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_err_ack) |-> $past(i_err_req))
        else note_failure("ack rose without a pending req");
    a_req_fall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_err_req) |-> $past(i_err_ack))
        else note_failure("req fell before ack rose");
    a_req_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_err_req) |-> !i_err_ack && !$past(i_err_ack))
        else note_failure("req rose while ack was still high");
    a_act: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_act_valid |-> i_act == exp_act)
        else note_failure($sformatf("ERROR t=%0t o_act got %0d exp %0d",
            $time, $sampled(i_act), $sampled(exp_act)));
    a_dis_mod: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_enable |=> !i_mod)
        else note_failure("o_mod not cleared one edge after disable");
    // an update needs a full high half and the low samples after enable
    a_dis_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_act_valid |-> en_cnt > i_cfg.half_period)
        else note_failure("actuator update while disabled or too soon after enable");

endmodule

// File: testbench/tb_dither_lock.sv
/*
 * dither lock testbench: runs a set of configurations against a two-level
 * plant model, the bound checker does the checking
 */
`timescale 1ns/100ps

module tb_dither_lock;

    import lock_cfg_pkg::*;

    localparam int ADC_BIT   = 14;
    localparam int ACT_BIT   = 16;
    localparam int NUM_TESTS = 7;
    localparam logic signed [ACT_BIT-1:0] ACT_MAX = {1'b0, {(ACT_BIT-1){1'b1}}};
    localparam logic signed [ACT_BIT-1:0] ACT_MIN = {1'b1, {(ACT_BIT-1){1'b0}}};

    logic                      i_clk;
    logic                      i_rst_n;
    logic                      i_enable;
    lock_cfg_t                 i_cfg;
    logic signed [ADC_BIT-1:0] i_adc_data;
    logic                      o_mod;
    lock_err_t                 o_err;
    logic signed [ACT_BIT-1:0] o_act;
    logic                      o_act_valid;

    logic signed [ADC_BIT-1:0] level_h;
    logic signed [ADC_BIT-1:0] level_l;
    lock_cfg_t                 tests [NUM_TESTS];
    int                        updates [NUM_TESTS];
    int                        cycle_cnt;
    int                        limit;
    logic                      seen_max;
    logic                      seen_min;

    dither_lock_top #(
        .ADC_BIT (ADC_BIT),
        .ACT_BIT (ACT_BIT)
    ) u_dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_enable    (i_enable),
        .i_cfg       (i_cfg),
        .i_adc_data  (i_adc_data),
        .o_mod       (o_mod),
        .o_err       (o_err),
        .o_act       (o_act),
        .o_act_valid (o_act_valid)
    );

    bind dither_lock_top dither_lock_chk #(.ACT_BIT(ACT_BIT)) u_chk (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_enable    (i_enable),
        .i_cfg       (i_cfg),
        .i_mod       (o_mod),
        .i_err       (o_err),
        .i_act       (o_act),
        .i_act_valid (o_act_valid),
        .i_err_req   (err_req),
        .i_err_ack   (err_ack)
    );

    function automatic lock_cfg_t build_cfg(input logic [15:0] hp, input logic [15:0] settle,
                                            input avg_len_e avg, input logic pol,
                                            input int offset, input logic [30:0] thr,
                                            input logic [3:0] gsh);
        lock_cfg_t c;
        c.half_period = hp;
        c.settle      = settle;
        c.avg_len     = avg;
        c.polarity    = pol;
        c.offset      = offset;
        c.threshold   = thr;
        c.gain_shift  = gsh;
        return c;
    endfunction

    task automatic abort_run(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    // reconfigure while disabled, then run until enough actuator updates
    task automatic run_config(input lock_cfg_t cfg, input int n_updates);
        int          seen;
        logic [31:0] rnd;
        seen = 0;
        @(posedge i_clk);
        #2;
        i_cfg   = cfg;
        rnd     = $urandom;
        level_h = rnd[ADC_BIT-1:0];
        rnd     = $urandom;
        level_l = rnd[ADC_BIT-1:0];
        repeat (2) @(posedge i_clk);
        #2;
        i_enable = 1'b1;
        while (seen < n_updates) begin
            @(posedge i_clk);
            #2;
            if (o_act_valid) begin
                seen++;
                if (o_act == ACT_MAX) seen_max = 1'b1;
                if (o_act == ACT_MIN) seen_min = 1'b1;
            end
        end
        i_enable = 1'b0;  // the demodulator is mid handoff here so no new sample is pending
        repeat (8) @(posedge i_clk);
    endtask

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // the plant model drives one level per modulation half
    always @(posedge i_clk) begin
        #2;
        i_adc_data = o_mod ? level_h : level_l;
    end

    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > limit) abort_run("timeout: the run did not finish within its cycle limit");
    end

    always @(negedge i_clk) begin
        if (u_dut.u_chk.fail_cnt != 0) abort_run("a checker assertion failed");
    end

    initial begin
        i_rst_n    = 1'b0;
        i_enable   = 1'b0;
        i_cfg      = '0;
        i_adc_data = '0;
        level_h    = '0;
        level_l    = '0;
        seen_max   = 1'b0;
        seen_min   = 1'b0;
        void'($urandom(86633));
        tests[0]   = build_cfg(16'd40, 16'd5, AVG_1, 1'b0, 0, 31'd0, 4'd2);
        tests[1]   = build_cfg(16'd50, 16'd3, AVG_8, 1'b1, 100, 31'd20, 4'd1);
        tests[2]   = build_cfg(16'd80, 16'd0, AVG_64, 1'b0, -50, 31'd10, 4'd3);
        tests[3]   = build_cfg(16'd30, 16'd2, AVG_16, 1'b0, 0, 31'h7fff_ffff, 4'd0);
        tests[4]   = build_cfg(16'd20, 16'd1, AVG_2, 1'b1, -300, 31'd5, 4'd4);
        tests[5]   = build_cfg(16'd24, 16'd1, AVG_4, 1'b0, 40000, 31'd0, 4'd0);
        tests[6]   = build_cfg(16'd40, 16'd3, AVG_32, 1'b1, 40000, 31'd0, 4'd0);
        updates    = '{4, 4, 3, 3, 4, 4, 4};
        // a handoff can skip a period, so allow two periods per update
        limit = 50;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit = limit + updates[t] * 4 * int'(tests[t].half_period) + 100;
        end
        repeat (10) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_config(tests[t], updates[t]);
        end
        @(posedge i_clk);
        #2;
        if (!(seen_max && seen_min)) begin
            abort_run("the actuator never reached both clamp limits");
        end else if (u_dut.u_chk.fail_cnt != 0) begin
            abort_run("a checker assertion failed");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule
